// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data_buffer testbench with Verilator.
# Exit status is zero only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_data_buffer \
  -o sim_tb_data_buffer
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/sim_tb_data_buffer)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
else
  echo "Pass line not found in simulation output"
  exit 1
fi

// ==== source/buffer_access_pkg.sv ====
/* Buffer access: opcodes of the fill and drain sides
   and the event passed from the fill side to the drain side */

package buffer_access_pkg;

  // ********************************************************
  // Fill side opcodes
  // ********************************************************

  // Decoded from store, flush and clear strobes
  // Flush and clear share one opcode, both empty the store
  typedef enum logic [1:0] {
    FILL_IDLE     = 2'd0,
    FILL_STORE_RX = 2'd1,
    FILL_STORE_TX = 2'd2,
    FILL_EMPTY    = 2'd3
  } fill_op_t;

  // ********************************************************
  // Drain side opcodes
  // ********************************************************

  // Decoded from the get strobes
  // get_rx_data beats get_tx_packet
  typedef enum logic [1:0] {
    DRAIN_IDLE   = 2'd0,
    DRAIN_GET_RX = 2'd1,
    DRAIN_GET_TX = 2'd2
  } drain_op_t;

  // ********************************************************
  // Fill to drain event
  // ********************************************************

  // What the fill side did this cycle
  // pushed   byte accepted into a bank
  // from_tx  accepted byte came from the bus slave side
  // emptied  flush or clear takes effect at this edge
  typedef struct packed {
    logic pushed;
    logic from_tx;
    logic emptied;
  } fill_event_t;

endpackage

// ==== source/buffer_bank.sv ====
/* One 16-byte storage bank of the endpoint buffer,
   written on the clock edge, read without a clock */

`timescale 1ns/1ps

module buffer_bank (
  input  logic                             tb_clk,
  input  buffer_geometry_pkg::bank_write_t wr,
  input  buffer_geometry_pkg::bank_addr_t  rd_addr,
  output buffer_geometry_pkg::data_byte_t  rd_data
);

  // ********************************************************
  // Storage
  // ********************************************************

  // Row array, one byte per row
  // Every fourth byte of the stream lands here
  buffer_geometry_pkg::data_byte_t mem [buffer_geometry_pkg::BANK_DEPTH];

  // ********************************************************
  // Write port
  // ********************************************************

  // Enable already qualified by the fill side
  // (bank select and full test both folded in)
  always_ff @(posedge tb_clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // ********************************************************
  // Read port
  // ********************************************************

  // Combinational read
  // Drain side needs the head byte in the get cycle itself
  // Row address is shared by all banks, the drain side
  // picks which bank output it actually uses
  assign rd_data = mem[rd_addr];

endmodule

// ==== source/buffer_drain_ctrl.sv ====
/* Drain control: decodes the get strobes, keeps the read pointer
   and occupancy count, and steers the head byte to its output */

`timescale 1ns/1ps

module buffer_drain_ctrl (
  input  logic                            tb_clk,
  input  logic                            reset,
  input  logic                            get_rx_data,
  input  logic                            get_tx_packet,
  input  buffer_access_pkg::fill_event_t  fill_event,
  input  buffer_geometry_pkg::data_byte_t bank_rd_data [buffer_geometry_pkg::NUM_BANKS],
  output buffer_geometry_pkg::bank_addr_t bank_rd_addr,
  output buffer_geometry_pkg::data_byte_t rx_data,
  output buffer_geometry_pkg::data_byte_t tx_packet_data,
  output buffer_geometry_pkg::occupancy_t buffer_occupancy
);

  localparam int SEL_W = buffer_geometry_pkg::BANK_SEL_WIDTH;
  localparam int PTR_W = buffer_geometry_pkg::PTR_WIDTH;

  buffer_access_pkg::drain_op_t      drain_op;
  buffer_geometry_pkg::buffer_ptr_t  rd_ptr;
  buffer_geometry_pkg::occupancy_t   occ_count;
  buffer_geometry_pkg::data_byte_t   head_byte;
  logic                              is_empty;
  logic                              pop_ok;

  // ********************************************************
  // Get decode
  // ********************************************************

  // RX side wins a tie
  always_comb begin
    if (get_rx_data) begin
      drain_op = buffer_access_pkg::DRAIN_GET_RX;
    end else if (get_tx_packet) begin
      drain_op = buffer_access_pkg::DRAIN_GET_TX;
    end else begin
      drain_op = buffer_access_pkg::DRAIN_IDLE;
    end
  end

  // Empty test on this side only
  assign is_empty = (occ_count == '0);
  // Get during flush/clear is dropped as well
  assign pop_ok = (drain_op != buffer_access_pkg::DRAIN_IDLE) && !is_empty &&
                  !fill_event.emptied;

  // ********************************************************
  // Head byte and outputs
  // ********************************************************

  // Row to every bank, low bits choose the bank
  assign bank_rd_addr = rd_ptr[PTR_W-1:SEL_W];
  assign head_byte    = bank_rd_data[rd_ptr[SEL_W-1:0]];

  // Loser output stays at zero
  assign rx_data        = (pop_ok && (drain_op == buffer_access_pkg::DRAIN_GET_RX)) ?
                          head_byte : '0;
  assign tx_packet_data = (pop_ok && (drain_op == buffer_access_pkg::DRAIN_GET_TX)) ?
                          head_byte : '0;

  // ********************************************************
  // Read pointer and occupancy
  // ********************************************************

  always_ff @(posedge tb_clk) begin
    if (reset || fill_event.emptied) begin
      rd_ptr    <= '0;
      occ_count <= '0;
    end else begin
      if (pop_ok) begin
        rd_ptr <= rd_ptr + buffer_geometry_pkg::buffer_ptr_t'(1);
      end
      // Push and pop together cancel out
      case ({fill_event.pushed, pop_ok})
        2'b10:   occ_count <= occ_count + buffer_geometry_pkg::occupancy_t'(1);
        2'b01:   occ_count <= occ_count - buffer_geometry_pkg::occupancy_t'(1);
        default: occ_count <= occ_count;
      endcase
    end
  end

  assign buffer_occupancy = occ_count;

endmodule

// ==== source/buffer_fill_ctrl.sv ====
/* Fill control: decodes store, flush and clear strobes,
   keeps the write pointer and steers each byte to its bank */

`timescale 1ns/1ps

module buffer_fill_ctrl (
  input  logic                             tb_clk,
  input  logic                             reset,
  input  logic                             store_rx_packet,
  input  logic                             store_tx_data,
  input  buffer_geometry_pkg::data_byte_t  rx_packet_data,
  input  buffer_geometry_pkg::data_byte_t  tx_data,
  input  logic                             flush,
  input  logic                             clear,
  input  buffer_geometry_pkg::occupancy_t  occupancy,
  output buffer_geometry_pkg::bank_write_t bank_wr [buffer_geometry_pkg::NUM_BANKS],
  output buffer_access_pkg::fill_event_t   fill_event
);

  localparam int SEL_W = buffer_geometry_pkg::BANK_SEL_WIDTH;
  localparam int PTR_W = buffer_geometry_pkg::PTR_WIDTH;

  buffer_access_pkg::fill_op_t       fill_op;
  buffer_geometry_pkg::data_byte_t   wr_byte;
  buffer_geometry_pkg::buffer_ptr_t  wr_ptr;
  buffer_geometry_pkg::bank_sel_t    wr_bank;
  buffer_geometry_pkg::bank_addr_t   wr_row;
  logic                              is_full;
  logic                              push_ok;

  // ********************************************************
  // Strobe decode
  // ********************************************************

  // Emptying first, then USB receiver, then bus slave
  always_comb begin
    if (flush || clear) begin
      fill_op = buffer_access_pkg::FILL_EMPTY;
    end else if (store_rx_packet) begin
      fill_op = buffer_access_pkg::FILL_STORE_RX;
    end else if (store_tx_data) begin
      fill_op = buffer_access_pkg::FILL_STORE_TX;
    end else begin
      fill_op = buffer_access_pkg::FILL_IDLE;
    end
  end

  // Byte from the winning source
  always_comb begin
    case (fill_op)
      buffer_access_pkg::FILL_STORE_RX: wr_byte = rx_packet_data;
      buffer_access_pkg::FILL_STORE_TX: wr_byte = tx_data;
      default:                          wr_byte = '0;
    endcase
  end

  // Full test lives here only, drain side never sees it
  assign is_full = (occupancy >= buffer_geometry_pkg::occupancy_t'(
                    buffer_geometry_pkg::BUFFER_DEPTH));

  // Store into a full buffer is simply dropped
  assign push_ok = ((fill_op == buffer_access_pkg::FILL_STORE_RX) ||
                    (fill_op == buffer_access_pkg::FILL_STORE_TX)) && !is_full;

  // ********************************************************
  // Bank steering
  // ********************************************************

  // Pointer split into bank select and row
  assign wr_bank = wr_ptr[SEL_W-1:0];
  assign wr_row  = wr_ptr[PTR_W-1:SEL_W];

  // Only the selected bank sees an enable
  always_comb begin
    for (int b = 0; b < buffer_geometry_pkg::NUM_BANKS; b++) begin
      bank_wr[b].en   = push_ok && (wr_bank == buffer_geometry_pkg::bank_sel_t'(b));
      bank_wr[b].addr = wr_row;
      bank_wr[b].data = wr_byte;
    end
  end

  // Event to the drain side, same cycle
  assign fill_event.pushed  = push_ok;
  assign fill_event.from_tx = push_ok && (fill_op == buffer_access_pkg::FILL_STORE_TX);
  assign fill_event.emptied = (fill_op == buffer_access_pkg::FILL_EMPTY);

  // ********************************************************
  // Write pointer
  // ********************************************************

  // Wraps at 64 on its own, pointer is exactly 6 bits
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (fill_event.emptied) begin
      wr_ptr <= '0;
    end else if (push_ok) begin
      wr_ptr <= wr_ptr + buffer_geometry_pkg::buffer_ptr_t'(1);
    end
  end

endmodule

// ==== source/buffer_geometry_pkg.sv ====
/* Buffer geometry: sizes, pointer and occupancy types,
   and the bank write bundle for the banked 64-byte endpoint store */

package buffer_geometry_pkg;

  // ********************************************************
  // Sizes
  // ********************************************************

  // One byte per entry
  localparam int DATA_WIDTH = 8;
  // Total capacity in bytes
  localparam int BUFFER_DEPTH = 64;
  // Interleaved banks, consecutive bytes rotate across them
  localparam int NUM_BANKS = 4;
  localparam int BANK_DEPTH = BUFFER_DEPTH / NUM_BANKS;

  // Derived widths
  localparam int PTR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS);
  localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);
  // One extra bit so that 64 fits
  localparam int OCC_WIDTH = $clog2(BUFFER_DEPTH) + 1;

  // ********************************************************
  // Types
  // ********************************************************

  typedef logic [DATA_WIDTH-1:0] data_byte_t;
  // Low bits pick the bank, high bits the row inside it
  typedef logic [PTR_WIDTH-1:0] buffer_ptr_t;
  typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;
  typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
  typedef logic [OCC_WIDTH-1:0] occupancy_t;

  // Write port of one bank
  typedef struct packed {
    logic       en;
    bank_addr_t addr;
    data_byte_t data;
  } bank_write_t;

endpackage

// ==== source/data_buffer.sv ====
/* Shared USB endpoint byte buffer: fill control, four interleaved
   banks and drain control around one 64-byte FIFO store */

`timescale 1ns/1ps

module data_buffer (
  input  logic                            tb_clk,
  input  logic                            reset,
  // Fill strobes
  input  logic                            store_rx_packet,
  input  logic                            store_tx_data,
  // Drain strobes
  input  logic                            get_rx_data,
  input  logic                            get_tx_packet,
  // Incoming bytes, USB receiver and bus slave
  input  buffer_geometry_pkg::data_byte_t rx_packet_data,
  input  buffer_geometry_pkg::data_byte_t tx_data,
  // Emptying strobes
  input  logic                            flush,
  input  logic                            clear,
  // Outgoing bytes, bus slave and USB transmitter
  output buffer_geometry_pkg::data_byte_t rx_data,
  output buffer_geometry_pkg::data_byte_t tx_packet_data,
  output buffer_geometry_pkg::occupancy_t buffer_occupancy
);

  // ********************************************************
  // Internal wiring
  // ********************************************************

  // Per bank write ports from the fill side
  buffer_geometry_pkg::bank_write_t bank_wr [buffer_geometry_pkg::NUM_BANKS];
  // Per bank read data to the drain side
  buffer_geometry_pkg::data_byte_t  bank_rd_data [buffer_geometry_pkg::NUM_BANKS];
  // Shared read row
  buffer_geometry_pkg::bank_addr_t  bank_rd_addr;
  // Push and empty events, fill to drain
  buffer_access_pkg::fill_event_t   fill_event;

  // ********************************************************
  // Fill side
  // ********************************************************

  // Occupancy fed back for the full test
  buffer_fill_ctrl u_fill_ctrl (
    .tb_clk          (tb_clk),
    .reset           (reset),
    .store_rx_packet (store_rx_packet),
    .store_tx_data   (store_tx_data),
    .rx_packet_data  (rx_packet_data),
    .tx_data         (tx_data),
    .flush           (flush),
    .clear           (clear),
    .occupancy       (buffer_occupancy),
    .bank_wr         (bank_wr),
    .fill_event      (fill_event)
  );

  // ********************************************************
  // Storage banks
  // ********************************************************

  // byte n of the stream goes to bank n mod 4
  for (genvar b = 0; b < buffer_geometry_pkg::NUM_BANKS; b++) begin : g_bank
    buffer_bank u_bank (
      .tb_clk  (tb_clk),
      .wr      (bank_wr[b]),
      .rd_addr (bank_rd_addr),
      .rd_data (bank_rd_data[b])
    );
  end

  // ********************************************************
  // Drain side
  // ********************************************************

  // Owns the occupancy count
  buffer_drain_ctrl u_drain_ctrl (
    .tb_clk           (tb_clk),
    .reset            (reset),
    .get_rx_data      (get_rx_data),
    .get_tx_packet    (get_tx_packet),
    .fill_event       (fill_event),
    .bank_rd_data     (bank_rd_data),
    .bank_rd_addr     (bank_rd_addr),
    .rx_data          (rx_data),
    .tx_packet_data   (tx_packet_data),
    .buffer_occupancy (buffer_occupancy)
  );

endmodule

// ==== sources.f ====
source/buffer_geometry_pkg.sv
source/buffer_access_pkg.sv
source/buffer_bank.sv
source/buffer_fill_ctrl.sv
source/buffer_drain_ctrl.sv
source/data_buffer.sv
verification/data_buffer_sva.sv
verification/tb_data_buffer.sv

// ==== verification/data_buffer_sva.sv ====
/* Assertion checker for the endpoint byte buffer,
   bound into the top level */

`timescale 1ns/1ps

module data_buffer_sva (
  input logic                            tb_clk,
  input logic                            reset,
  input logic                            get_rx_data,
  input logic                            get_tx_packet,
  input logic                            flush,
  input logic                            clear,
  input buffer_geometry_pkg::data_byte_t rx_data,
  input buffer_geometry_pkg::data_byte_t tx_packet_data,
  input buffer_geometry_pkg::occupancy_t buffer_occupancy
);

  // ********************************************************
  // Occupancy
  // ********************************************************

  // Never above capacity
  occ_in_range: assert property (@(posedge tb_clk) disable iff (reset)
    buffer_occupancy <= buffer_geometry_pkg::occupancy_t'(buffer_geometry_pkg::BUFFER_DEPTH))
    else $error("buffer_occupancy above capacity: %0d", buffer_occupancy);

  // Emptying lands at the next edge
  occ_zero_after_empty: assert property (@(posedge tb_clk) disable iff (reset)
    (flush || clear) |=> (buffer_occupancy == '0))
    else $error("buffer_occupancy not zero after flush or clear");

  // ********************************************************
  // Outputs
  // ********************************************************

  // Quiet output without its own strobe
  rx_zero_idle: assert property (@(posedge tb_clk) disable iff (reset)
    !get_rx_data |-> (rx_data == '0))
    else $error("rx_data nonzero without get_rx_data");

  tx_zero_idle: assert property (@(posedge tb_clk) disable iff (reset)
    !get_tx_packet |-> (tx_packet_data == '0))
    else $error("tx_packet_data nonzero without get_tx_packet");

endmodule

// ==== verification/tb_data_buffer.sv ====
/* Testbench for the shared endpoint byte buffer: runs a table of strobe
   steps against a queue model and checks occupancy and both outputs */

`timescale 1ns/1ps

module tb_data_buffer;

  // ********************************************************
  // Constants and types
  // ********************************************************

  localparam int RESET_CYCLES  = 4;
  localparam int RESET_TIMEOUT = 20;

  // One bit per external strobe, order as in the table columns
  typedef struct packed {
    logic store_rx;
    logic store_tx;
    logic get_rx;
    logic get_tx;
    logic flush;
    logic clear;
  } strobe_t;

  // ********************************************************
  // DUT signals
  // ********************************************************

  logic                            tb_clk;
  logic                            reset;
  logic                            store_rx_packet;
  logic                            store_tx_data;
  logic                            get_rx_data;
  logic                            get_tx_packet;
  buffer_geometry_pkg::data_byte_t rx_packet_data;
  buffer_geometry_pkg::data_byte_t tx_data;
  logic                            flush;
  logic                            clear;
  buffer_geometry_pkg::data_byte_t rx_data;
  buffer_geometry_pkg::data_byte_t tx_packet_data;
  buffer_geometry_pkg::occupancy_t buffer_occupancy;

  // Step table, one entry per test
  strobe_t                         step_strobes [$];
  buffer_geometry_pkg::data_byte_t step_data [$];
  bit                              step_random [$];
  int                              step_count [$];
  string                           step_name [$];

  // Expected contents, head at index 0
  buffer_geometry_pkg::data_byte_t model_q [$];

  integer                          seed = 32'hf16e;
  int                              error_count = 0;
  int                              failed_tests = 0;
  int                              wait_cycles = 0;
  buffer_geometry_pkg::data_byte_t step_byte;

  data_buffer u_data_buffer (
    .tb_clk           (tb_clk),
    .reset            (reset),
    .store_rx_packet  (store_rx_packet),
    .store_tx_data    (store_tx_data),
    .get_rx_data      (get_rx_data),
    .get_tx_packet    (get_tx_packet),
    .rx_packet_data   (rx_packet_data),
    .tx_data          (tx_data),
    .flush            (flush),
    .clear            (clear),
    .rx_data          (rx_data),
    .tx_packet_data   (tx_packet_data),
    .buffer_occupancy (buffer_occupancy)
  );

  // Checker sits inside the top level
  bind data_buffer data_buffer_sva u_data_buffer_sva (
    .tb_clk           (tb_clk),
    .reset            (reset),
    .get_rx_data      (get_rx_data),
    .get_tx_packet    (get_tx_packet),
    .flush            (flush),
    .clear            (clear),
    .rx_data          (rx_data),
    .tx_packet_data   (tx_packet_data),
    .buffer_occupancy (buffer_occupancy)
  );

  // ********************************************************
  // Clock and reset
  // ********************************************************

  initial tb_clk = 1'b0;
  always #50 tb_clk = ~tb_clk;

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge tb_clk);
    reset <= 1'b0;
  end

  // ********************************************************
  // Compare tasks
  // ********************************************************

  task automatic check_occupancy(input buffer_geometry_pkg::occupancy_t actual,
                                 input buffer_geometry_pkg::occupancy_t expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: buffer_occupancy is %0d, expected %0d",
               $time, actual, expected);
      error_count++;
    end
  endtask

  task automatic check_byte(input buffer_geometry_pkg::data_byte_t actual,
                            input buffer_geometry_pkg::data_byte_t expected,
                            input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is 8'h%02h, expected 8'h%02h",
               $time, what, actual, expected);
      error_count++;
    end
  endtask

  // ********************************************************
  // Stimulus and model
  // ********************************************************

  task automatic add_step(input strobe_t st, input buffer_geometry_pkg::data_byte_t d,
                          input bit rnd, input int count, input string name);
    step_strobes.push_back(st);
    step_data.push_back(d);
    step_random.push_back(rnd);
    step_count.push_back(count);
    step_name.push_back(name);
  endtask

  // tx_data carries the inverse when both stores fire, so a wrong pick shows
  task automatic drive_step(input strobe_t st, input buffer_geometry_pkg::data_byte_t b);
    store_rx_packet <= st.store_rx;
    store_tx_data   <= st.store_tx;
    get_rx_data     <= st.get_rx;
    get_tx_packet   <= st.get_tx;
    flush           <= st.flush;
    clear           <= st.clear;
    rx_packet_data  <= b;
    tx_data         <= st.store_rx ? ~b : b;
  endtask

  // Called mid-cycle, compares then advances the model over the next edge
  task automatic check_cycle(input strobe_t st, input buffer_geometry_pkg::data_byte_t b);
    buffer_geometry_pkg::data_byte_t exp_rx;
    buffer_geometry_pkg::data_byte_t exp_tx;
    buffer_geometry_pkg::data_byte_t in_byte;
    logic emptying;
    logic do_pop;
    logic do_push;
    int   depth;
    depth    = model_q.size();
    emptying = st.flush || st.clear;
    exp_rx   = '0;
    exp_tx   = '0;
    // Receiver side wins both ties
    in_byte  = st.store_rx ? rx_packet_data : tx_data;
    do_pop   = !emptying && (st.get_rx || st.get_tx) && (depth > 0);
    do_push  = !emptying && (st.store_rx || st.store_tx) &&
               (depth < buffer_geometry_pkg::BUFFER_DEPTH);
    if (do_pop && st.get_rx) begin
      exp_rx = model_q[0];
    end else if (do_pop) begin
      exp_tx = model_q[0];
    end
    check_occupancy(buffer_occupancy, buffer_geometry_pkg::occupancy_t'(depth));
    check_byte(rx_data, exp_rx, "rx_data");
    check_byte(tx_packet_data, exp_tx, "tx_packet_data");
    if (emptying) begin
      model_q.delete();
    end else begin
      if (do_pop) begin
        void'(model_q.pop_front());
      end
      if (do_push) begin
        model_q.push_back(in_byte);
      end
    end
  endtask

  task automatic run_tests();
    int errors_before;
    for (int s = 0; s < step_strobes.size(); s++) begin
      errors_before = error_count;
      for (int r = 0; r < step_count[s]; r++) begin
        if (step_random[s]) begin
          step_byte = buffer_geometry_pkg::data_byte_t'($random(seed));
        end else begin
          step_byte = step_data[s] + buffer_geometry_pkg::data_byte_t'(r);
        end
        @(posedge tb_clk);
        drive_step(step_strobes[s], step_byte);
        @(negedge tb_clk);
        check_cycle(step_strobes[s], step_byte);
      end
      if (error_count == errors_before) begin
        $display("Test %s passed", step_name[s]);
      end else begin
        $display("Test %s failed with %0d errors", step_name[s], error_count - errors_before);
        failed_tests++;
      end
    end
    $display("Done: %0d tests, %0d failed, %0d mismatches",
             step_strobes.size(), failed_tests, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // ********************************************************
  // Main sequence
  // ********************************************************

  initial begin
    store_rx_packet = 1'b0;
    store_tx_data   = 1'b0;
    get_rx_data     = 1'b0;
    get_tx_packet   = 1'b0;
    flush           = 1'b0;
    clear           = 1'b0;
    rx_packet_data  = '0;
    tx_data         = '0;
    // Columns: store_rx store_tx get_rx get_tx flush clear, base byte, random
    add_step(6'b000000, 8'h00, 1'b0,  2, "reset_state");
    add_step(6'b100000, 8'h00, 1'b0, 64, "fill_rx_to_full");
    add_step(6'b100000, 8'hee, 1'b0,  1, "store_when_full");
    add_step(6'b001000, 8'h00, 1'b0, 64, "drain_rx_in_order");
    add_step(6'b001000, 8'h00, 1'b0,  1, "get_when_empty");
    add_step(6'b010000, 8'h00, 1'b1,  8, "store_tx_random");
    add_step(6'b000100, 8'h00, 1'b0,  8, "drain_tx_in_order");
    add_step(6'b100000, 8'h40, 1'b0, 32, "fill_before_clear");
    add_step(6'b000001, 8'h00, 1'b0,  1, "clear");
    add_step(6'b100000, 8'h5a, 1'b0,  1, "store_after_clear");
    add_step(6'b001000, 8'h00, 1'b0,  1, "get_after_clear");
    add_step(6'b010000, 8'h80, 1'b0, 10, "fill_before_flush");
    add_step(6'b000010, 8'h00, 1'b0,  1, "flush");
    add_step(6'b010000, 8'ha5, 1'b0,  1, "store_after_flush");
    add_step(6'b000100, 8'h00, 1'b0,  1, "get_after_flush");
    add_step(6'b110000, 8'h10, 1'b0,  4, "both_stores");
    add_step(6'b001100, 8'h00, 1'b0,  2, "both_gets");
    add_step(6'b101000, 8'h20, 1'b0,  3, "store_and_get");
    // One byte stays behind so the flush below has something to block
    add_step(6'b000100, 8'h00, 1'b0,  1, "drain_all_but_one");
    add_step(6'b101010, 8'h30, 1'b0,  1, "flush_blocks_store_get");
    add_step(6'b100000, 8'h77, 1'b0,  1, "store_after_blocked_flush");
    add_step(6'b001000, 8'h00, 1'b0,  1, "get_after_blocked_flush");
    add_step(6'b000000, 8'h00, 1'b0,  1, "final_idle");
    // Reset release, bounded
    while (reset && (wait_cycles < RESET_TIMEOUT)) begin
      @(negedge tb_clk);
      wait_cycles++;
    end
    if (reset) begin
      $display("Reset was still high after %0d cycles, giving up", RESET_TIMEOUT);
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      run_tests();
    end
  end

endmodule
